//--- rtl/soc_bus_pkg.sv
// memory map, access sizes, bus request/response structs, timer read-word union
package soc_bus_pkg;

  // ==================================================
  // address map
  // ==================================================
  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] DMEM_BASE  = 32'h8000_0000;
  localparam logic [XLEN-1:0] DMEM_MASK  = 32'hFFF0_0000;  // 1 MB, words alias inside
  localparam logic [XLEN-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [XLEN-1:0] CLINT_MASK = 32'hFFFF_0000;  // 64 KB
  localparam logic [XLEN-1:0] UART_BASE  = 32'h1000_0000;
  localparam logic [XLEN-1:0] UART_MASK  = 32'hFFFF_F000;  // 4 KB

  // timer register offsets
  localparam logic [15:0] TIMER_MSIP_OFS = 16'h0000;
  localparam logic [15:0] TIMER_CMP_OFS  = 16'h4000;
  localparam logic [15:0] TIMER_TIME_OFS = 16'hBFF8;

  // uart register offsets, byte spaced
  localparam logic [2:0] UART_THR_OFS = 3'd0;  // tx holding / rx on read
  localparam logic [2:0] UART_LSR_OFS = 3'd5;  // line status
  localparam logic [2:0] UART_SCR_OFS = 3'd7;  // scratch

  // ==================================================
  // bus types
  // ==================================================
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'd0,
    SIZE_HALF  = 3'd1,
    SIZE_WORD  = 3'd2,
    SIZE_DWORD = 3'd3
  } size_e;

  // master side request, held while valid && !ready
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
    logic [63:0]     wdata;
    logic            we;
    size_e           size;
  } bus_req_t;

  // request after decode, offset inside the window
  typedef struct packed {
    logic        valid;
    logic [15:0] offset;
    logic [63:0] wdata;
    logic        we;
    size_e       size;
  } slave_req_t;

  typedef struct packed {
    logic        ready;
    logic [63:0] rdata;
  } bus_rsp_t;

  // one 64-bit read word, viewed at any access size
  typedef union packed {
    logic [63:0]      dword;
    logic [1:0][31:0] words;
    logic [3:0][15:0] halves;
    logic [7:0][7:0]  bytes;
  } rdata_u;

endpackage

//--- rtl/simple_bus.sv
// address decoder, request router and response mux for the peripheral bus
`timescale 1ns/1ps

module simple_bus import soc_bus_pkg::*; (
  input  logic       clk,         // used by bound checks only
  input  logic       rst_n,       // used by bound checks only
  input  bus_req_t   master_req,
  output bus_rsp_t   master_rsp,
  output slave_req_t dmem_req,
  output slave_req_t timer_req,
  output slave_req_t uart_req,
  input  bus_rsp_t   dmem_rsp,
  input  bus_rsp_t   timer_rsp,
  input  bus_rsp_t   uart_rsp
);

  // ==================================================
  // address decode
  // ==================================================
  logic sel_timer;
  logic sel_uart;
  logic sel_dmem;

  // priority timer > uart > dmem
  assign sel_timer = ((master_req.addr & CLINT_MASK) == CLINT_BASE);
  assign sel_uart  = !sel_timer && ((master_req.addr & UART_MASK) == UART_BASE);
  assign sel_dmem  = !sel_timer && !sel_uart &&
                     ((master_req.addr & DMEM_MASK) == DMEM_BASE);

  // pick the timer lane by size and low address bits, zero extended
  function automatic logic [63:0] timer_lane(rdata_u rd, size_e size, logic [2:0] ofs);
    logic [63:0] lane;
    unique case (size)
      SIZE_BYTE:  lane = {56'h0, rd.bytes[ofs]};
      SIZE_HALF:  lane = {48'h0, rd.halves[ofs[2:1]]};
      SIZE_WORD:  lane = {32'h0, rd.words[ofs[2]]};
      default:    lane = rd.dword;  // dword
    endcase
    return lane;
  endfunction

  // ==================================================
  // request routing
  // ==================================================
  slave_req_t routed;  // common fields, valid filled per slave

  always_comb begin
    routed        = '0;
    routed.offset = master_req.addr[15:0];  // window offset
    routed.wdata  = master_req.wdata;
    routed.we     = master_req.we;
    routed.size   = master_req.size;
  end

  always_comb begin
    dmem_req  = '0;  // idle slaves see all zero
    timer_req = '0;
    uart_req  = '0;
    if (master_req.valid) begin
      if (sel_timer) begin
        timer_req       = routed;
        timer_req.valid = 1'b1;
      end else if (sel_uart) begin
        uart_req       = routed;
        uart_req.valid = 1'b1;
        uart_req.wdata = {56'h0, master_req.wdata[7:0]};  // byte wide slave
      end else if (sel_dmem) begin
        dmem_req       = routed;
        dmem_req.valid = 1'b1;
      end
    end
  end

  // ==================================================
  // response mux
  // ==================================================
  rdata_u timer_rd;

  always_comb begin
    timer_rd.dword = timer_rsp.rdata;
    master_rsp     = '0;
    if (sel_timer) begin
      master_rsp.ready = timer_rsp.ready;
      master_rsp.rdata = timer_lane(timer_rd, master_req.size, master_req.addr[2:0]);
    end else if (sel_uart) begin
      master_rsp.ready = uart_rsp.ready;  // low while tx busy
      master_rsp.rdata = {56'h0, uart_rsp.rdata[7:0]};
    end else if (sel_dmem) begin
      master_rsp.ready = dmem_rsp.ready;
      master_rsp.rdata = dmem_rsp.rdata;
    end else begin
      // unmapped address completes at once with zero so the master never hangs
      master_rsp.ready = master_req.valid;
      master_rsp.rdata = 64'h0;
    end
  end

endmodule

//--- rtl/data_ram.sv
// dword-wide data RAM with byte-lane writes by size and offset
`timescale 1ns/1ps

module data_ram import soc_bus_pkg::*; #(
  parameter int DMEM_WORDS = 256  // at most 8192, index from offset[15:3]
) (
  input  logic       clk,
  input  slave_req_t req,
  output bus_rsp_t   rsp
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [63:0]      mem [DMEM_WORDS];  // no reset of contents
  logic [IDX_W-1:0] idx;
  logic [2:0]       byte_ofs;
  logic [7:0]       size_mask;  // lanes before shifting
  logic [7:0]       byte_en;
  logic [63:0]      wdata_sh;   // write data moved to its lane
  logic [63:0]      merged;

  // addresses past the array alias back into it
  assign idx      = IDX_W'(req.offset[15:3] % DMEM_WORDS);
  assign byte_ofs = req.offset[2:0];

  always_comb begin
    unique case (req.size)
      SIZE_BYTE: size_mask = 8'h01;
      SIZE_HALF: size_mask = 8'h03;
      SIZE_WORD: size_mask = 8'h0F;
      default:   size_mask = 8'hFF;
    endcase
  end

  assign byte_en  = size_mask << byte_ofs;  // lanes past byte 7 fall off
  assign wdata_sh = req.wdata << {byte_ofs, 3'b000};

  // merge new lanes into the stored dword
  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < 8; b++) begin
      if (byte_en[b]) merged[8*b +: 8] = wdata_sh[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (req.valid && req.we) begin  // ready == valid
      mem[idx] <= merged;
    end
  end

  assign rsp.ready = req.valid;    // single cycle
  assign rsp.rdata = mem[idx];     // full aligned dword

endmodule

//--- rtl/core_timer.sv
// core-local timer with mtime, mtimecmp, msip and the timer and software irqs
`timescale 1ns/1ps

module core_timer import soc_bus_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  slave_req_t req,
  output bus_rsp_t   rsp,
  output logic       timer_irq,
  output logic       soft_irq
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        msip;
  logic        sel_msip;
  logic        sel_cmp;
  logic        sel_time;
  logic        wr;

  // match on the dword, offset[2] picks the half
  assign sel_msip = (req.offset[15:3] == TIMER_MSIP_OFS[15:3]);
  assign sel_cmp  = (req.offset[15:3] == TIMER_CMP_OFS[15:3]);
  assign sel_time = (req.offset[15:3] == TIMER_TIME_OFS[15:3]);
  assign wr       = req.valid && req.we;

  // dword replaces, word replaces one half, others leave it alone
  function automatic logic [63:0] wr_merge(logic [63:0] old, logic [63:0] wdata,
                                           size_e size, logic hi);
    logic [63:0] nv;
    nv = old;
    if (size == SIZE_DWORD) nv = wdata;
    else if (size == SIZE_WORD && hi) nv[63:32] = wdata[31:0];
    else if (size == SIZE_WORD) nv[31:0] = wdata[31:0];
    return nv;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime    <= 64'h0;
      mtimecmp <= '1;  // no irq out of reset
      msip     <= 1'b0;
    end else begin
      if (wr && sel_time) mtime <= wr_merge(mtime, req.wdata, req.size, req.offset[2]);
      else mtime <= mtime + 64'd1;  // free running
      if (wr && sel_cmp) mtimecmp <= wr_merge(mtimecmp, req.wdata, req.size, req.offset[2]);
      if (wr && sel_msip && !req.offset[2]) msip <= req.wdata[0];
    end
  end

  // full register back, bus picks the lane
  always_comb begin
    rsp.ready = req.valid;
    if (sel_msip) rsp.rdata = {63'h0, msip};
    else if (sel_cmp) rsp.rdata = mtimecmp;
    else if (sel_time) rsp.rdata = mtime;
    else rsp.rdata = 64'h0;
  end

  assign timer_irq = (mtime >= mtimecmp);
  assign soft_irq  = msip;

endmodule

//--- rtl/uart_regs.sv
// uart register block with tx holding reg, busy countdown, line status and scratch
`timescale 1ns/1ps

module uart_regs import soc_bus_pkg::*; #(
  parameter int UART_TX_CYCLES = 4  // busy cycles per tx byte
) (
  input  logic       clk,
  input  logic       rst_n,
  input  slave_req_t req,
  output bus_rsp_t   rsp,
  output logic       tx_valid,
  output logic [7:0] tx_data
);

  localparam int CNT_W = $clog2(UART_TX_CYCLES + 1);

  logic [CNT_W-1:0] busy_cnt;
  logic             busy;
  logic             thr_wr;   // tx write presented
  logic             tx_take;  // tx write accepted
  logic [7:0]       scr;
  logic [7:0]       rd_byte;

  assign busy    = (busy_cnt != '0);
  assign thr_wr  = req.valid && req.we && (req.offset[2:0] == UART_THR_OFS);
  assign tx_take = thr_wr && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_cnt <= '0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= tx_take;  // strobe one cycle after accept
      if (tx_take) busy_cnt <= CNT_W'(UART_TX_CYCLES);
      else if (busy) busy_cnt <= busy_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tx_take) tx_data <= req.wdata[7:0];
    if (req.valid && req.we && req.offset[2:0] == UART_SCR_OFS) scr <= req.wdata[7:0];
  end

  always_comb begin
    unique case (req.offset[2:0])
      UART_LSR_OFS: rd_byte = {1'b0, !busy, !busy, 5'b0};  // thre, temt
      UART_SCR_OFS: rd_byte = scr;
      default:      rd_byte = 8'h00;  // rx and the rest read 0
    endcase
  end

  assign rsp.ready = req.valid && !(thr_wr && busy);  // stall while busy
  assign rsp.rdata = {56'h0, rd_byte};

endmodule

//--- rtl/periph_subsys_top.sv
// peripheral subsystem top with bus, data RAM, core timer and uart
`timescale 1ns/1ps

module periph_subsys_top import soc_bus_pkg::*; #(
  parameter int DMEM_WORDS     = 256,
  parameter int UART_TX_CYCLES = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  bus_req_t   master_req,
  output bus_rsp_t   master_rsp,
  output logic       timer_irq,
  output logic       soft_irq,
  output logic       tx_valid,
  output logic [7:0] tx_data
);

  slave_req_t dmem_req, timer_req, uart_req;
  bus_rsp_t   dmem_rsp, timer_rsp, uart_rsp;

  // ==================================================
  // interconnect and slaves
  // ==================================================
  simple_bus u_simple_bus (
    .clk(clk), .rst_n(rst_n), .master_req(master_req), .master_rsp(master_rsp),
    .dmem_req(dmem_req), .timer_req(timer_req), .uart_req(uart_req),
    .dmem_rsp(dmem_rsp), .timer_rsp(timer_rsp), .uart_rsp(uart_rsp)
  );

  data_ram #(.DMEM_WORDS(DMEM_WORDS)) u_data_ram (
    .clk(clk), .req(dmem_req), .rsp(dmem_rsp)
  );

  core_timer u_core_timer (
    .clk(clk), .rst_n(rst_n), .req(timer_req), .rsp(timer_rsp),
    .timer_irq(timer_irq), .soft_irq(soft_irq)
  );

  uart_regs #(.UART_TX_CYCLES(UART_TX_CYCLES)) u_uart_regs (
    .clk(clk), .rst_n(rst_n), .req(uart_req), .rsp(uart_rsp),
    .tx_valid(tx_valid), .tx_data(tx_data)
  );

endmodule

//--- verification/periph_subsys_asserts.sv
// decode and handshake checks on the peripheral bus, bound into simple_bus
`timescale 1ns/1ps

module periph_subsys_asserts import soc_bus_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input bus_req_t   master_req,
  input bus_rsp_t   master_rsp,
  input slave_req_t dmem_req,
  input slave_req_t timer_req,
  input slave_req_t uart_req
);

  logic any_slave;  // some slave request valid
  logic unmapped;   // address outside all three windows

  assign any_slave = dmem_req.valid || timer_req.valid || uart_req.valid;
  assign unmapped  = ((master_req.addr & CLINT_MASK) != CLINT_BASE) &&
                     ((master_req.addr & UART_MASK) != UART_BASE) &&
                     ((master_req.addr & DMEM_MASK) != DMEM_BASE);

  // ==================================================
  // decode
  // ==================================================
  a_one_slave: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({dmem_req.valid, timer_req.valid, uart_req.valid}))
    else $error("more than one slave request valid");

  // holes complete at once with zero and reach no slave
  a_unmapped_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (master_req.valid && unmapped) |->
      (master_rsp.ready && master_rsp.rdata == 64'h0 && !any_slave))
    else $error("unmapped request without ready and zero data");

  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    any_slave |-> master_req.valid)
    else $error("slave request valid without a master request");

endmodule

bind simple_bus periph_subsys_asserts u_asserts (
  .clk(clk), .rst_n(rst_n), .master_req(master_req), .master_rsp(master_rsp),
  .dmem_req(dmem_req), .timer_req(timer_req), .uart_req(uart_req)
);

//--- verification/tb_periph_subsys.sv
// testbench for the peripheral subsystem, ops and expected values from a test data file
`timescale 1ns/1ps

module tb_periph_subsys import soc_bus_pkg::*; ();

  localparam int DMEM_WORDS = 256;
  localparam int TX_CYCLES  = 4;
  localparam int TIMEOUT    = 50;  // cycles allowed per wait

  logic        clk;
  logic        rst_n;
  bus_req_t    master_req;
  bus_rsp_t    master_rsp;
  logic        timer_irq;
  logic        soft_irq;
  logic        tx_valid;
  logic [7:0]  tx_data;

  logic [63:0] ram_model [DMEM_WORDS];  // mirror of the data RAM
  logic [7:0]  tx_q [$];                // bytes seen on the tx strobe
  int          seed = 22616;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  bit          op_bad;

  periph_subsys_top #(.DMEM_WORDS(DMEM_WORDS), .UART_TX_CYCLES(TX_CYCLES)) u_periph_subsys_top (
    .clk(clk), .rst_n(rst_n), .master_req(master_req), .master_rsp(master_rsp),
    .timer_irq(timer_irq), .soft_irq(soft_irq), .tx_valid(tx_valid), .tx_data(tx_data)
  );

  always #10 clk = ~clk;  // 20 ns period

  always @(negedge clk) begin
    if (rst_n && tx_valid) tx_q.push_back(tx_data);  // strobe is one full cycle
  end

  // ==================================================
  // helpers
  // ==================================================
  // low 2^size bytes of wdata land at byte offset ofs, rest kept
  function automatic logic [63:0] lane_merge(logic [63:0] old, logic [63:0] wdata, int size,
                                             logic [2:0] ofs);
    rdata_u m;
    rdata_u w;
    m.dword = old;
    w.dword = wdata;
    for (int b = 0; b < (1 << size); b++) begin
      if (ofs + b < 8) m.bytes[ofs + b] = w.bytes[b];
    end
    return m.dword;
  endfunction

  task automatic show_mismatch(input string sig, input logic [63:0] exp, input logic [63:0] got);
    $display("[ERROR] %0t %s expected %h got %h", $time, sig, exp, got);
    op_bad = 1'b1;
  endtask

  // drive one transfer on the edge and sample ready at negedge until it rises
  task automatic bus_xfer(input logic [31:0] addr, input int size, input logic we,
                          input logic [63:0] wdata, output logic [63:0] rdata,
                          output int stall, output bit tmo);
    @(posedge clk);
    master_req <= '{valid: 1'b1, addr: addr, wdata: wdata, we: we, size: size_e'(size)};
    stall = 0;
    @(negedge clk);
    while (!master_rsp.ready && stall < TIMEOUT) begin
      @(negedge clk);
      stall++;  // cycles held off
    end
    tmo   = !master_rsp.ready;
    rdata = master_rsp.rdata;
    @(posedge clk);
    master_req <= '0;  // back to idle
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int               fd;
    int               n;
    int               size;
    int               stall;
    int               cycles;
    int               idx;
    bit               tmo;
    logic [7:0]       op;
    logic [31:0]      addr;
    logic [63:0]      wdata;
    logic [63:0]      exp;
    logic [63:0]      got;
    logic [8*128-1:0] skip;
    clk        = 1'b0;
    rst_n      = 1'b0;
    master_req = '0;
    fd = $fopen("verification/periph_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      fail_cnt++;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    while (fd != 0 && !$feof(fd)) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1) break;  // trailing whitespace at eof
      if (op == "#") begin
        n = $fgets(skip, fd);  // column notes
        continue;
      end
      n      = $fscanf(fd, "%h %h %h %h", addr, size, wdata, exp);
      op_bad = 1'b0;
      tmo    = 1'b0;
      idx    = int'(addr[15:3]) % DMEM_WORDS;  // RAM aliases by dword index
      case (op)
        "D", "W": begin
          if (op == "D") wdata = {$random(seed), $random(seed)};
          bus_xfer(addr, size, 1'b1, wdata, got, stall, tmo);
          if ((addr & DMEM_MASK) == DMEM_BASE)
            ram_model[idx] = lane_merge(ram_model[idx], wdata, size, addr[2:0]);
          if (op == "W") begin
            assert (stall == int'(exp)) else show_mismatch("ready stall", exp, 64'(stall));
          end
        end
        "R", "M": begin
          bus_xfer(addr, size, 1'b0, 64'h0, got, stall, tmo);
          if (op == "M") exp = ram_model[idx];
          assert (got == exp) else show_mismatch("master_rsp.rdata", exp, got);
        end
        "X": begin
          cycles = 0;
          while (tx_q.size() == 0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
          end
          tmo = (tx_q.size() == 0);
          if (!tmo) begin
            got = 64'(tx_q.pop_front());
            assert (got == exp) else show_mismatch("tx_data", exp, got);
          end
        end
        "I": begin  // exp = fewest cycles before the irq may rise
          cycles = 0;
          @(negedge clk);
          while (!timer_irq && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
          end
          tmo = !timer_irq;
          assert (tmo || cycles >= int'(exp))
            else show_mismatch("timer_irq delay", exp, 64'(cycles));
        end
        "S": begin
          @(negedge clk);
          assert (soft_irq == exp[0]) else show_mismatch("soft_irq", exp, 64'(soft_irq));
        end
        default: begin
          $display("unknown op code %s in the test data", op);
          op_bad = 1'b1;
        end
      endcase
      if (tmo) begin
        $display("timed out after %0d cycles on op %s at address %h", TIMEOUT, op, addr);
        op_bad = 1'b1;
      end
      if (op_bad) fail_cnt++;
      else pass_cnt++;
      $display("test %0d: %s %h %s", pass_cnt + fail_cnt, op, addr, op_bad ? "fail" : "pass");
    end

    // every strobe must have been claimed by an X op
    op_bad = 1'b0;
    assert (tx_q.size() == 0)
      else show_mismatch("tx_valid extra strobes", 64'h0, 64'(tx_q.size()));
    if (op_bad) fail_cnt++;
    else pass_cnt++;
    $display("test %0d: tx strobe count %s", pass_cnt + fail_cnt, op_bad ? "fail" : "pass");

    if (fd != 0) $fclose(fd);
    $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verification/periph_testdata.txt
# columns: op addr size wdata exp, all hex; W exp = ready stall cycles, R exp = read data
# D random dword write, M read vs RAM model, X tx byte, I min cycles to timer irq, S soft irq
D 80000010 3 0 0
W 80000013 0 a5 0
M 80000010 3 0 0
W 80000016 1 beef 0
W 80000010 2 12345678 0
M 80000010 3 0 0
W 02004000 3 1122334455667788 0
R 02004003 0 0 55
R 02004006 1 0 1122
R 02004004 2 0 11223344
W 02004004 2 aabbccdd 0
R 02004000 3 0 aabbccdd55667788
W 02004000 3 14 0
W 0200bff8 3 0 0
I 0 0 0 14
W 02000000 2 1 0
S 0 0 0 1
W 02000000 2 0 0
S 0 0 0 0
W 10000000 0 41 0
W 10000000 0 42 3
R 10000005 0 0 0
X 0 0 0 41
X 0 0 0 42
W 10000007 0 5a 0
R 10000007 0 0 5a
R 10000005 0 0 60
R 0c000000 3 0 0
R 20000000 3 0 0
W 80000808 3 cafef00d12345678 0
R 80000008 3 0 cafef00d12345678

//--- filelist.f
rtl/soc_bus_pkg.sv
rtl/simple_bus.sv
rtl/data_ram.sv
rtl/core_timer.sv
rtl/uart_regs.sv
rtl/periph_subsys_top.sv
verification/periph_subsys_asserts.sv
verification/tb_periph_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the peripheral subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_periph_subsys -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0
